/* rtl/dma_pkg.sv */
package dma_pkg;

    // ----------------------------------------------------------------------
    // address and word geometry
    // ----------------------------------------------------------------------
    localparam int AddrWidth     = 32;
    localparam int LenWidth      = 16;
    localparam int WordBytes     = 8;
    localparam int WordAddrWidth = 29;
    localparam int OffsetWidth   = 3;

    typedef logic [7:0] byte_t;

    // memory word picked apart by byte or handled whole
    typedef union packed {
        byte_t [WordBytes-1:0]  bytes;
        logic [8*WordBytes-1:0] data;
    } word_t;

    typedef logic [WordBytes-1:0] strb_t;

    // ----------------------------------------------------------------------
    // transfer descriptor and memory port
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [AddrWidth-1:0] src;
        logic [AddrWidth-1:0] dst;
        logic [LenWidth-1:0]  num_bytes;
    } dma_desc_t;

    typedef struct packed {
        logic                     valid;
        logic [WordAddrWidth-1:0] addr;
    } mem_rd_req_t;

    // valid exactly one cycle after the request
    typedef struct packed {
        logic  valid;
        word_t data;
    } mem_rd_rsp_t;

    typedef struct packed {
        logic                     valid;
        logic [WordAddrWidth-1:0] addr;
        strb_t                    strb;
        word_t                    data;
    } mem_wr_req_t;

    // one destination word as seen by the write side
    typedef struct packed {
        logic [WordAddrWidth-1:0] addr;
        strb_t                    strb;
        logic                     last;
    } wr_beat_t;

endpackage

/* rtl/dma_launch_ctrl.sv */
`timescale 1ns/1ns

module dma_launch_ctrl (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               launch_req_i,
    input  dma_pkg::dma_desc_t launch_desc_i,
    output logic               launch_ack_o,
    output logic               idle_o,
    output logic               start_o,
    output dma_pkg::dma_desc_t desc_o,
    input  logic               rd_done_i,
    input  logic               wr_done_i
);
    import dma_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACK,
        ST_RUN
    } state_e;

    state_e    state_q;
    logic      ack_q;
    logic      idle_q;
    logic      start_q;
    logic      rd_seen_q;
    logic      wr_seen_q;
    dma_desc_t desc_q;
    logic      accept;
    logic      rd_all;
    logic      wr_all;

    // previous ack has to be down before the next request counts
    assign accept = (state_q == ST_IDLE) && launch_req_i && !ack_q && idle_q;
    assign rd_all = rd_seen_q || rd_done_i;
    assign wr_all = wr_seen_q || wr_done_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            ack_q     <= 1'b0;
            idle_q    <= 1'b1;
            start_q   <= 1'b0;
            rd_seen_q <= 1'b0;
            wr_seen_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (accept) begin
                ack_q <= 1'b1;
            end else if (!launch_req_i) begin
                ack_q <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    idle_q <= 1'b1;
                    if (accept) begin
                        state_q <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    idle_q    <= 1'b0;
                    rd_seen_q <= 1'b0;
                    wr_seen_q <= 1'b0;
                    // empty transfer has nothing to start
                    if (desc_q.num_bytes == '0) begin
                        state_q <= ST_IDLE;
                    end else begin
                        start_q <= 1'b1;
                        state_q <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    rd_seen_q <= rd_all;
                    wr_seen_q <= wr_all;
                    if (rd_all && wr_all) begin
                        idle_q  <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            desc_q <= launch_desc_i;
        end
    end

    assign launch_ack_o = ack_q;
    assign idle_o       = idle_q;
    assign start_o      = start_q;
    assign desc_o       = desc_q;

    // done pulses only come back while a transfer runs
    done_run_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        (rd_done_i || wr_done_i) |-> (state_q == ST_RUN));

endmodule

/* rtl/dma_read_stream.sv */
`timescale 1ns/1ns

module dma_read_stream (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 start_i,
    input  dma_pkg::dma_desc_t   desc_i,
    input  logic                 buf_space_i,
    output dma_pkg::mem_rd_req_t mem_rd_req_o,
    input  dma_pkg::mem_rd_rsp_t mem_rd_rsp_i,
    output dma_pkg::mem_rd_rsp_t rd_word_o,
    output logic                 rd_done_o
);
    import dma_pkg::*;

    logic [AddrWidth-1:0]     src_end;
    logic [WordAddrWidth-1:0] addr_q;
    logic [WordAddrWidth-1:0] last_q;
    logic                     active_q;
    logic [1:0]               inflight_q;
    logic                     issue;

    // byte address of the last source byte
    assign src_end = desc_i.src + AddrWidth'(desc_i.num_bytes) - AddrWidth'(1);

    assign issue              = active_q && buf_space_i;
    assign mem_rd_req_o.valid = issue;
    assign mem_rd_req_o.addr  = addr_q;
    assign rd_word_o          = mem_rd_rsp_i;

    // final reply comes with nothing left to issue and one read outstanding
    assign rd_done_o = mem_rd_rsp_i.valid && !active_q && (inflight_q == 2'd1);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q   <= 1'b0;
            inflight_q <= '0;
        end else begin
            if (start_i) begin
                active_q <= 1'b1;
            end else if (issue && (addr_q == last_q)) begin
                active_q <= 1'b0;
            end
            inflight_q <= inflight_q + 2'(issue) - 2'(mem_rd_rsp_i.valid);
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            addr_q <= desc_i.src[AddrWidth-1:OffsetWidth];
            last_q <= src_end[AddrWidth-1:OffsetWidth];
        end else if (issue) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    // buffer space in dma_realign counts on a single reply in flight
    rd_inflight_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_rd_rsp_i.valid |-> (inflight_q == 2'd1));

endmodule

/* rtl/dma_write_stream.sv */
`timescale 1ns/1ns

module dma_write_stream (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               start_i,
    input  dma_pkg::dma_desc_t desc_i,
    output dma_pkg::wr_beat_t  beat_o,
    output logic               beat_valid_o,
    input  logic               beat_ready_i
);
    import dma_pkg::*;

    logic [AddrWidth-1:0]     dst_end;
    logic [WordAddrWidth-1:0] addr_q;
    logic [WordAddrWidth-1:0] last_q;
    logic [OffsetWidth-1:0]   lo_off_q;
    logic [OffsetWidth-1:0]   hi_off_q;
    logic                     first_q;
    logic                     active_q;
    logic                     is_last;
    logic                     fire;
    strb_t                    lo_mask;
    strb_t                    hi_mask;

    assign dst_end = desc_i.dst + AddrWidth'(desc_i.num_bytes) - AddrWidth'(1);
    assign is_last = (addr_q == last_q);
    assign fire    = active_q && beat_ready_i;

    // trim below the start offset on the first word and above the end on the last
    assign lo_mask = first_q ? ({WordBytes{1'b1}} << lo_off_q) : {WordBytes{1'b1}};
    assign hi_mask = is_last ? ({WordBytes{1'b1}} >> (OffsetWidth'(WordBytes - 1) - hi_off_q))
                             : {WordBytes{1'b1}};

    assign beat_o.addr  = addr_q;
    assign beat_o.strb  = lo_mask & hi_mask;
    assign beat_o.last  = is_last;
    assign beat_valid_o = active_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q <= 1'b0;
            first_q  <= 1'b0;
        end else if (start_i) begin
            active_q <= 1'b1;
            first_q  <= 1'b1;
        end else if (fire) begin
            first_q <= 1'b0;
            if (is_last) begin
                active_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            addr_q   <= desc_i.dst[AddrWidth-1:OffsetWidth];
            last_q   <= dst_end[AddrWidth-1:OffsetWidth];
            lo_off_q <= desc_i.dst[OffsetWidth-1:0];
            hi_off_q <= dst_end[OffsetWidth-1:0];
        end else if (fire) begin
            addr_q <= addr_q + 1'b1;
        end
    end

endmodule

/* rtl/dma_realign.sv */
`timescale 1ns/1ns

module dma_realign #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 start_i,
    input  dma_pkg::dma_desc_t   desc_i,
    input  dma_pkg::mem_rd_rsp_t rd_word_i,
    output logic                 buf_space_o,
    input  dma_pkg::wr_beat_t    beat_i,
    input  logic                 beat_valid_i,
    output logic                 beat_ready_o,
    output dma_pkg::mem_wr_req_t mem_wr_req_o,
    output logic                 wr_done_o
);
    import dma_pkg::*;

    localparam int PtrWidth = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CntWidth = $clog2(BUF_DEPTH + 1);

    word_t                    fifo_mem [BUF_DEPTH];
    logic [PtrWidth-1:0]      wr_ptr_q;
    logic [PtrWidth-1:0]      rd_ptr_q;
    logic [CntWidth-1:0]      count_q;
    logic                     push;
    logic                     pop;
    logic                     empty;

    word_t                    head;
    word_t                    prev_q;
    logic                     preload_q;
    logic [OffsetWidth:0]     shift_q;
    logic [OffsetWidth-1:0]   off_diff;
    byte_t [2*WordBytes-1:0]  win;
    word_t                    beat_data;
    strb_t                    head_mask;
    logic                     need_head;
    logic                     fire;

    logic                     wr_valid_q;
    logic                     wr_last_q;
    logic [WordAddrWidth-1:0] wr_addr_q;
    strb_t                    wr_strb_q;
    word_t                    wr_data_q;

    // ----------------------------------------------------------------------
    // window over the source bytes
    // ----------------------------------------------------------------------
    // prev_q holds the low word and the FIFO head the high word
    assign off_diff = desc_i.src[OffsetWidth-1:0] - desc_i.dst[OffsetWidth-1:0];
    assign empty    = (count_q == '0);
    assign head     = fifo_mem[rd_ptr_q];
    assign win      = {head.bytes, prev_q.bytes};

    always_comb begin
        for (int k = 0; k < WordBytes; k++) begin
            beat_data.bytes[k] = win[k + int'(shift_q)];
        end
    end

    // destination bytes that land in the head word
    assign head_mask = {WordBytes{1'b1}} << ((OffsetWidth + 1)'(WordBytes) - shift_q);
    assign need_head = |(beat_i.strb & head_mask);

    assign beat_ready_o = !preload_q && (!need_head || !empty);
    assign fire         = beat_valid_i && beat_ready_o;

    // fixed reply latency keeps at most one read on its way
    assign buf_space_o = (count_q <= CntWidth'(BUF_DEPTH - 2));

    assign push = rd_word_i.valid;
    assign pop  = (preload_q && !empty) || (fire && need_head);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            preload_q  <= 1'b0;
            wr_valid_q <= 1'b0;
            wr_last_q  <= 1'b0;
        end else begin
            if (start_i) begin
                wr_ptr_q  <= '0;
                rd_ptr_q  <= '0;
                count_q   <= '0;
                // source ahead of destination in the word needs one word fetched early
                preload_q <= desc_i.src[OffsetWidth-1:0] > desc_i.dst[OffsetWidth-1:0];
            end else begin
                if (push) begin
                    wr_ptr_q <= (wr_ptr_q == PtrWidth'(BUF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
                end
                if (pop) begin
                    rd_ptr_q <= (rd_ptr_q == PtrWidth'(BUF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
                end
                count_q <= count_q + CntWidth'(push) - CntWidth'(pop);
                if (preload_q && !empty) begin
                    preload_q <= 1'b0;
                end
            end
            wr_valid_q <= fire;
            wr_last_q  <= fire && beat_i.last;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= rd_word_i.data;
        end
        if (pop) begin
            prev_q <= head;
        end
        // shift of 8 means the beat comes straight from the head word
        if (start_i) begin
            shift_q <= (off_diff == '0) ? (OffsetWidth + 1)'(WordBytes) : {1'b0, off_diff};
        end
        if (fire) begin
            wr_addr_q <= beat_i.addr;
            wr_strb_q <= beat_i.strb;
            wr_data_q <= beat_data;
        end
    end

    // ----------------------------------------------------------------------
    // memory write port
    // ----------------------------------------------------------------------
    assign mem_wr_req_o.valid = wr_valid_q;
    assign mem_wr_req_o.addr  = wr_addr_q;
    assign mem_wr_req_o.strb  = wr_strb_q;
    assign mem_wr_req_o.data  = wr_data_q;

    // high together with the final write
    assign wr_done_o = wr_last_q;

    wr_strb_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_wr_req_o.valid |-> (mem_wr_req_o.strb != '0));

    // relies on the read side holding off when buf_space_o is low
    fifo_ovf_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        (push && !pop) |-> (count_q < CntWidth'(BUF_DEPTH)));

endmodule

/* rtl/dma_engine.sv */
`timescale 1ns/1ns

module dma_engine #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 launch_req_i,
    input  dma_pkg::dma_desc_t   launch_desc_i,
    output logic                 launch_ack_o,
    output logic                 idle_o,
    output dma_pkg::mem_rd_req_t mem_rd_req_o,
    input  dma_pkg::mem_rd_rsp_t mem_rd_rsp_i,
    output dma_pkg::mem_wr_req_t mem_wr_req_o
);
    import dma_pkg::*;

    logic        start;
    dma_desc_t   desc;
    logic        rd_done;
    logic        wr_done;
    logic        buf_space;
    mem_rd_rsp_t rd_word;
    wr_beat_t    beat;
    logic        beat_valid;
    logic        beat_ready;

    dma_launch_ctrl u_launch_ctrl (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .launch_req_i  (launch_req_i),
        .launch_desc_i (launch_desc_i),
        .launch_ack_o  (launch_ack_o),
        .idle_o        (idle_o),
        .start_o       (start),
        .desc_o        (desc),
        .rd_done_i     (rd_done),
        .wr_done_i     (wr_done)
    );

    dma_read_stream u_read_stream (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .start_i      (start),
        .desc_i       (desc),
        .buf_space_i  (buf_space),
        .mem_rd_req_o (mem_rd_req_o),
        .mem_rd_rsp_i (mem_rd_rsp_i),
        .rd_word_o    (rd_word),
        .rd_done_o    (rd_done)
    );

    dma_write_stream u_write_stream (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .start_i      (start),
        .desc_i       (desc),
        .beat_o       (beat),
        .beat_valid_o (beat_valid),
        .beat_ready_i (beat_ready)
    );

    dma_realign #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_realign (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .start_i      (start),
        .desc_i       (desc),
        .rd_word_i    (rd_word),
        .buf_space_o  (buf_space),
        .beat_i       (beat),
        .beat_valid_i (beat_valid),
        .beat_ready_o (beat_ready),
        .mem_wr_req_o (mem_wr_req_o),
        .wr_done_o    (wr_done)
    );

endmodule

/* dv/dma_mem_model.sv */
`timescale 1ns/1ns

module dma_mem_model #(
    parameter int SEED      = 32'h599b,
    parameter int NUM_WORDS = 64
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  dma_pkg::mem_rd_req_t rd_req_i,
    output dma_pkg::mem_rd_rsp_t rd_rsp_o,
    input  dma_pkg::mem_wr_req_t wr_req_i
);
    import dma_pkg::*;

    localparam int IdxWidth = $clog2(NUM_WORDS);

    word_t mem [NUM_WORDS];
    int    seed;

    // random contents with one draw per half word
    initial begin
        seed = SEED;
        for (int i = 0; i < NUM_WORDS; i++) begin
            mem[i].data = {$random(seed), $random(seed)};
        end
    end

    // ----------------------------------------------------------------------
    // one-cycle read, strobed write
    // ----------------------------------------------------------------------
    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_rsp_o.valid <= 1'b0;
        end else begin
            rd_rsp_o.valid <= rd_req_i.valid;
            if (rd_req_i.valid) begin
                rd_rsp_o.data <= mem[rd_req_i.addr[IdxWidth-1:0]];
            end
            if (wr_req_i.valid) begin
                for (int k = 0; k < WordBytes; k++) begin
                    if (wr_req_i.strb[k]) begin
                        mem[wr_req_i.addr[IdxWidth-1:0]].bytes[k] <= wr_req_i.data.bytes[k];
                    end
                end
            end
        end
    end

endmodule

/* dv/dma_tb.sv */
`timescale 1ns/1ns

module dma_tb;
    import dma_pkg::*;

    localparam int MemBytes      = 512;
    localparam int TimeoutCycles = 500;

    logic        clk;
    logic        arst_n;
    logic        launch_req;
    dma_desc_t   launch_desc;
    logic        launch_ack;
    logic        idle;
    mem_rd_req_t mem_rd_req;
    mem_rd_rsp_t mem_rd_rsp;
    mem_wr_req_t mem_wr_req;

    byte_t ref_mem [MemBytes];
    int    seed;
    int    errors = 0;
    int    assert_errors = 0;
    int    test_start = 0;
    int    num_tests = 0;
    int    num_failed = 0;
    logic  full_strb_chk;
    logic  quiet_chk;
    logic  idle_before_ack;

    dma_engine #(
        .BUF_DEPTH (4)
    ) u_dut (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .launch_req_i  (launch_req),
        .launch_desc_i (launch_desc),
        .launch_ack_o  (launch_ack),
        .idle_o        (idle),
        .mem_rd_req_o  (mem_rd_req),
        .mem_rd_rsp_i  (mem_rd_rsp),
        .mem_wr_req_o  (mem_wr_req)
    );

    dma_mem_model #(
        .SEED      (32'h599b),
        .NUM_WORDS (MemBytes / WordBytes)
    ) u_mem (
        .clk      (clk),
        .arst_n_i (arst_n),
        .rd_req_i (mem_rd_req),
        .rd_rsp_o (mem_rd_rsp),
        .wr_req_i (mem_wr_req)
    );

    always #10 clk = ~clk;

    // ----------------------------------------------------------------------
    // handshake and port rules
    // ----------------------------------------------------------------------
    ack_req_a: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(launch_ack) |-> $past(launch_req))
        else begin
            $display("acknowledge rose without a pending request");
            assert_errors++;
        end

    ack_drop_a: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(launch_ack) |-> !$past(launch_req))
        else begin
            $display("acknowledge dropped while the request was still high");
            assert_errors++;
        end

    ack_idle_a: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(launch_ack) |-> $past(idle))
        else begin
            $display("request acknowledged while a transfer was running");
            assert_errors++;
        end

    strb_full_a: assert property (@(posedge clk) disable iff (!arst_n)
        (full_strb_chk && mem_wr_req.valid) |-> (mem_wr_req.strb == 8'hff))
        else begin
            $display("mismatch mem_wr_req.strb: got 0x%02h expected 0xff",
                     $sampled(mem_wr_req.strb));
            assert_errors++;
        end

    // zero-length launch must stay off the memory port
    quiet_a: assert property (@(posedge clk) disable iff (!arst_n)
        quiet_chk |-> (!mem_rd_req.valid && !mem_wr_req.valid))
        else begin
            $display("memory accessed during a zero-length transfer");
            assert_errors++;
        end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    task automatic expect_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic take_snapshot();
        for (int a = 0; a < MemBytes; a++) begin
            ref_mem[a] = u_mem.mem[a / WordBytes].bytes[a % WordBytes];
        end
    endtask

    // each destination byte takes the source byte at the same distance
    task automatic apply_copy(input int src, input int dst, input int n);
        for (int j = 0; j < n; j++) begin
            ref_mem[dst + j] = ref_mem[src + j];
        end
    endtask

    task automatic launch_handshake(input int src, input int dst, input int n, input int hold);
        int cnt;
        launch_desc.src       = AddrWidth'(src);
        launch_desc.dst       = AddrWidth'(dst);
        launch_desc.num_bytes = LenWidth'(n);
        launch_req            = 1'b1;
        idle_before_ack       = 1'b0;
        cnt = 0;
        while (!launch_ack && cnt < TimeoutCycles) begin
            if (idle) begin
                idle_before_ack = 1'b1;
            end
            @(posedge clk);
            #2;
            cnt++;
        end
        if (!launch_ack) begin
            $display("timeout: launch at src 0x%03h was never acknowledged", src);
            errors++;
        end
        // request stays up a few cycles so ack has to wait for it
        repeat (hold) begin
            @(posedge clk);
            #2;
        end
        launch_req = 1'b0;
        cnt = 0;
        while (launch_ack && cnt < TimeoutCycles) begin
            @(posedge clk);
            #2;
            cnt++;
        end
        if (launch_ack) begin
            $display("timeout: acknowledge stayed high after the request dropped");
            errors++;
        end
    endtask

    // idle has to go low and come back
    task automatic wait_done();
        int   cnt;
        logic busy;
        busy = !idle;
        cnt  = 0;
        while (!(busy && idle) && cnt < TimeoutCycles) begin
            @(posedge clk);
            #2;
            cnt++;
            if (!idle) begin
                busy = 1'b1;
            end
        end
        if (!(busy && idle)) begin
            $display("timeout: engine did not return to idle");
            errors++;
        end
    endtask

    task automatic check_mem();
        byte_t got;
        for (int a = 0; a < MemBytes; a++) begin
            got = u_mem.mem[a / WordBytes].bytes[a % WordBytes];
            assert (got == ref_mem[a]) else begin
                $display("mismatch u_mem.mem byte 0x%03h: got 0x%02h expected 0x%02h",
                         a, got, ref_mem[a]);
                errors++;
            end
        end
    endtask

    task automatic run_copy(input int src, input int dst, input int n);
        take_snapshot();
        apply_copy(src, dst, n);
        launch_handshake(src, dst, n, 0);
        wait_done();
        check_mem();
    endtask

    task automatic end_test(input string name);
        int now_errors;
        now_errors = errors + assert_errors;
        num_tests++;
        if (now_errors != test_start) begin
            num_failed++;
        end
        $display("test %s: %s", name, (now_errors == test_start) ? "ok" : "failed");
        test_start = now_errors;
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        int n;
        int a;
        int b;
        clk           = 1'b0;
        arst_n        = 1'b0;
        launch_req    = 1'b0;
        launch_desc   = '0;
        full_strb_chk = 1'b0;
        quiet_chk     = 1'b0;
        seed          = 32'h599b;
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;

        expect_bit("launch_ack_o", launch_ack, 1'b0);
        expect_bit("idle_o", idle, 1'b1);
        expect_bit("mem_rd_req_o.valid", mem_rd_req.valid, 1'b0);
        expect_bit("mem_wr_req_o.valid", mem_wr_req.valid, 1'b0);
        end_test("reset");

        full_strb_chk = 1'b1;
        run_copy(0, 256, 32);
        full_strb_chk = 1'b0;
        end_test("aligned");

        // src offset 5 and dst offset 2
        run_copy(69, 418, 19);
        end_test("unaligned");

        quiet_chk = 1'b1;
        run_copy(16, 272, 0);
        quiet_chk = 1'b0;
        end_test("zero_length");

        // low half and high half never overlap
        for (int t = 0; t < 20; t++) begin
            n = $unsigned($random(seed)) % 65;
            a = $unsigned($random(seed)) % 192;
            b = 256 + $unsigned($random(seed)) % 192;
            if (($random(seed) & 1) != 0) begin
                run_copy(b, a, n);
            end else begin
                run_copy(a, b, n);
            end
        end
        end_test("random");

        // second request raised while the first copy runs
        take_snapshot();
        apply_copy(8, 384, 64);
        apply_copy(195, 453, 40);
        launch_handshake(8, 384, 64, 3);
        launch_handshake(195, 453, 40, 0);
        assert (idle_before_ack) else begin
            $display("second request acknowledged before idle_o rose");
            errors++;
        end
        wait_done();
        check_mem();
        end_test("handshake");

        $display("%0d tests, %0d failed, %0d errors",
                 num_tests, num_failed, errors + assert_errors);
        if (errors + assert_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
rtl/dma_pkg.sv
rtl/dma_launch_ctrl.sv
rtl/dma_read_stream.sv
rtl/dma_write_stream.sv
rtl/dma_realign.sv
rtl/dma_engine.sv
dv/dma_mem_model.sv
dv/dma_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module dma_tb -o dma_tb_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/dma_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    exit 0
else
    echo "pass line not found in $LOG"
    exit 1
fi
